/* hdl/eth_pkg.sv */
`default_nettype none

package eth_pkg;

  // stream and address widths
  typedef logic [63:0] word_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // host register port
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [15:0] count_t;

  // register map
  localparam reg_addr_t REG_CTRL       = 4'd0;
  localparam reg_addr_t REG_LOCAL_IP   = 4'd1;
  localparam reg_addr_t REG_LOCAL_PORT = 4'd2;
  localparam reg_addr_t REG_TX_FRAMES  = 4'd3;
  localparam reg_addr_t REG_RX_GOOD    = 4'd4;
  localparam reg_addr_t REG_RX_BAD     = 4'd5;

  typedef enum logic [1:0] {TX_IDLE, TX_HDR0, TX_HDR1, TX_DATA} tx_state_t;

  typedef enum logic [1:0] {RX_HDR0, RX_HDR1, RX_DATA, RX_DROP} rx_state_t;

  typedef enum logic [1:0] {RST_IDLE, RST_HOLD, RST_ACK} rst_state_t;

endpackage

`default_nettype wire

/* hdl/eth_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface eth_cfg_if;
  import eth_pkg::*;

  // configuration from the register block
  logic      enable;
  ip_addr_t  local_ip;
  udp_port_t local_port;

  // one-cycle frame events back to the counters
  logic      tx_frame_done;
  logic      rx_frame_good;
  logic      rx_frame_bad;

  modport regs (
    output enable, local_ip, local_port,
    input  tx_frame_done, rx_frame_good, rx_frame_bad
  );

  modport tx (
    input  enable, local_ip, local_port,
    output tx_frame_done
  );

  modport rx (
    input  enable, local_ip, local_port,
    output rx_frame_good, rx_frame_bad
  );

endinterface

`default_nettype wire

/* hdl/eth_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_regs (
  input  logic               clk,
  input  logic               mac_resetRR,
  input  logic               reg_wr,
  input  logic               reg_rd,
  input  eth_pkg::reg_addr_t reg_addr,
  input  eth_pkg::reg_data_t reg_wdata,
  output eth_pkg::reg_data_t reg_rdata,
  output logic               reg_rvalid,
  eth_cfg_if.regs            cfg,
  output logic               soft_reset_req,
  input  logic               soft_reset_ack
);
  import eth_pkg::*;

  logic      enable_q;
  ip_addr_t  local_ip_q;
  udp_port_t local_port_q;
  count_t    tx_frames;
  count_t    rx_good;
  count_t    rx_bad;
  reg_data_t read_mux;

  assign cfg.enable     = enable_q;
  assign cfg.local_ip   = local_ip_q;
  assign cfg.local_port = local_port_q;

  // configuration and soft reset request
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      enable_q       <= 1'b0;
      local_ip_q     <= '0;
      local_port_q   <= '0;
      soft_reset_req <= 1'b0;
    end else begin
      if (soft_reset_ack) begin
        soft_reset_req <= 1'b0;
      end
      if (reg_wr) begin
        case (reg_addr)
          REG_CTRL: begin
            enable_q <= reg_wdata[0];
            if (reg_wdata[1]) begin
              soft_reset_req <= 1'b1;
            end
          end
          REG_LOCAL_IP: begin
            local_ip_q <= reg_wdata;
          end
          REG_LOCAL_PORT: begin
            local_port_q <= reg_wdata[15:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // frame counters, wrap at full scale
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      tx_frames <= '0;
      rx_good   <= '0;
      rx_bad    <= '0;
    end else begin
      if (cfg.tx_frame_done) begin
        tx_frames <= tx_frames + 1'b1;
      end
      if (cfg.rx_frame_good) begin
        rx_good <= rx_good + 1'b1;
      end
      if (cfg.rx_frame_bad) begin
        rx_bad <= rx_bad + 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_addr)
      REG_CTRL:       read_mux = {30'b0, soft_reset_req, enable_q};
      REG_LOCAL_IP:   read_mux = local_ip_q;
      REG_LOCAL_PORT: read_mux = {16'b0, local_port_q};
      REG_TX_FRAMES:  read_mux = {16'b0, tx_frames};
      REG_RX_GOOD:    read_mux = {16'b0, rx_good};
      REG_RX_BAD:     read_mux = {16'b0, rx_bad};
      default:        read_mux = '0;
    endcase
  end

  // read data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_rd) begin
      reg_rdata <= read_mux;
    end
  end

endmodule

`default_nettype wire

/* hdl/eth_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               clk,
  input  logic               app_rst,
  input  logic               push,
  input  eth_pkg::word_t     word,
  input  logic               eof,
  input  eth_pkg::ip_addr_t  dest_ip,
  input  eth_pkg::udp_port_t dest_port,
  input  logic               pop,
  output eth_pkg::word_t     head_word,
  output logic               head_eof,
  output eth_pkg::ip_addr_t  head_ip,
  output eth_pkg::udp_port_t head_port,
  output logic               empty,
  output logic               overflow
);
  import eth_pkg::*;

  // depth is a power of two, pointers carry one wrap bit
  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  word_t       word_mem [FIFO_DEPTH];
  logic        eof_mem  [FIFO_DEPTH];
  ip_addr_t    ip_mem   [FIFO_DEPTH];
  udp_port_t   port_mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  always_ff @(posedge clk) begin
    if (push && !full) begin
      word_mem[wr_ptr[AW-1:0]] <= word;
      eof_mem[wr_ptr[AW-1:0]]  <= eof;
      ip_mem[wr_ptr[AW-1:0]]   <= dest_ip;
      port_mem[wr_ptr[AW-1:0]] <= dest_port;
    end
  end

  always_ff @(posedge clk) begin
    if (app_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // word dropped when full
      overflow <= push && full;
    end
  end

  assign head_word = word_mem[rd_ptr[AW-1:0]];
  assign head_eof  = eof_mem[rd_ptr[AW-1:0]];
  assign head_ip   = ip_mem[rd_ptr[AW-1:0]];
  assign head_port = port_mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

/* hdl/eth_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_framer (
  input  logic               clk,
  input  logic               app_rst,
  eth_cfg_if.tx              cfg,
  input  logic               tx_valid,
  output logic               accept,
  input  eth_pkg::word_t     head_word,
  input  logic               head_eof,
  input  eth_pkg::ip_addr_t  head_ip,
  input  eth_pkg::udp_port_t head_port,
  input  logic               empty,
  output logic               pop,
  output logic               mac_tx_valid,
  output logic               mac_tx_last,
  output eth_pkg::word_t     mac_tx_data
);
  import eth_pkg::*;

  tx_state_t state;
  tx_state_t state_next;
  logic      take;

  // app words only enter the buffer while enabled
  assign accept = tx_valid && cfg.enable;

  assign take = (state == TX_DATA) && !empty;
  assign pop  = take;

  always_comb begin
    state_next = state;
    case (state)
      TX_IDLE: begin
        if (!empty) begin
          state_next = TX_HDR0;
        end
      end
      TX_HDR0: state_next = TX_HDR1;
      TX_HDR1: state_next = TX_DATA;
      TX_DATA: begin
        if (take && head_eof) begin
          state_next = TX_IDLE;
        end
      end
      default: state_next = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (app_rst) begin
      state <= TX_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // headers come from the head entry, which stays put until TX_DATA
  always_comb begin
    mac_tx_valid = 1'b0;
    mac_tx_data  = head_word;
    case (state)
      TX_HDR0: begin
        mac_tx_valid = 1'b1;
        mac_tx_data  = {head_ip, cfg.local_ip};
      end
      TX_HDR1: begin
        mac_tx_valid = 1'b1;
        mac_tx_data  = {head_port, cfg.local_port, 32'b0};
      end
      TX_DATA: begin
        mac_tx_valid = take;
      end
      default: begin
      end
    endcase
  end

  assign mac_tx_last       = take && head_eof;
  assign cfg.tx_frame_done = mac_tx_last;

endmodule

`default_nettype wire

/* hdl/eth_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_parser (
  input  logic               clk,
  input  logic               app_rst,
  eth_cfg_if.rx              cfg,
  input  logic               mac_rx_valid,
  input  logic               mac_rx_last,
  input  eth_pkg::word_t     mac_rx_data,
  input  logic               mac_rx_bad,
  output logic               rx_valid,
  output logic               rx_end_of_frame,
  output eth_pkg::word_t     rx_data,
  output eth_pkg::ip_addr_t  rx_source_ip,
  output eth_pkg::udp_port_t rx_source_port,
  output logic               rx_bad_frame
);
  import eth_pkg::*;

  rx_state_t state;
  logic      ip_ok;
  logic      hdr_ok;

  // decided on the second header word
  assign hdr_ok = ip_ok && (mac_rx_data[63:48] == cfg.local_port) && cfg.enable;

  always_ff @(posedge clk) begin
    if (app_rst) begin
      state             <= RX_HDR0;
      rx_valid          <= 1'b0;
      rx_end_of_frame   <= 1'b0;
      rx_bad_frame      <= 1'b0;
      cfg.rx_frame_good <= 1'b0;
      cfg.rx_frame_bad  <= 1'b0;
    end else begin
      rx_valid          <= 1'b0;
      rx_end_of_frame   <= 1'b0;
      rx_bad_frame      <= 1'b0;
      cfg.rx_frame_good <= 1'b0;
      cfg.rx_frame_bad  <= 1'b0;
      if (mac_rx_valid) begin
        case (state)
          RX_HDR0: begin
            // a one-word frame is too short
            if (!mac_rx_last) begin
              state <= RX_HDR1;
            end
          end
          RX_HDR1: begin
            if (mac_rx_last) begin
              state <= RX_HDR0;
            end else if (hdr_ok) begin
              state <= RX_DATA;
            end else begin
              state <= RX_DROP;
            end
          end
          RX_DATA: begin
            rx_valid          <= 1'b1;
            rx_end_of_frame   <= mac_rx_last;
            rx_bad_frame      <= mac_rx_last && mac_rx_bad;
            cfg.rx_frame_good <= mac_rx_last && !mac_rx_bad;
            cfg.rx_frame_bad  <= mac_rx_last && mac_rx_bad;
            if (mac_rx_last) begin
              state <= RX_HDR0;
            end
          end
          default: begin
            if (mac_rx_last) begin
              state <= RX_HDR0;
            end
          end
        endcase
      end
    end
  end

  // header fields and payload
  always_ff @(posedge clk) begin
    if (mac_rx_valid) begin
      case (state)
        RX_HDR0: begin
          rx_source_ip <= mac_rx_data[31:0];
          ip_ok        <= (mac_rx_data[63:32] == cfg.local_ip);
        end
        RX_HDR1: begin
          rx_source_port <= mac_rx_data[47:32];
        end
        RX_DATA: begin
          rx_data <= mac_rx_data;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/eth_soft_reset.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_soft_reset #(
  parameter int RESET_HOLD = 8
) (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic soft_reset_req,
  output logic soft_reset_ack,
  output logic app_rst
);
  import eth_pkg::*;

  localparam int HOLD_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD) : 1;

  rst_state_t        state;
  logic [HOLD_W-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state    <= RST_IDLE;
      hold_cnt <= '0;
    end else begin
      case (state)
        RST_IDLE: begin
          hold_cnt <= '0;
          if (soft_reset_req) begin
            state <= RST_HOLD;
          end
        end
        RST_HOLD: begin
          if (hold_cnt == HOLD_W'(RESET_HOLD - 1)) begin
            state <= RST_ACK;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: begin
          // register block drops the request after the ack
          if (!soft_reset_req) begin
            state <= RST_IDLE;
          end
        end
      endcase
    end
  end

  assign soft_reset_ack = (state == RST_ACK) && soft_reset_req;

  // data paths also follow the core reset
  assign app_rst = mac_resetRR || (state == RST_HOLD);

endmodule

`default_nettype wire

/* hdl/eth_led_stretch.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_led_stretch #(
  parameter int LED_WIDTH = 24
) (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic phy_up,
  input  logic tx_event,
  input  logic rx_event,
  output logic led_up,
  output logic led_rx,
  output logic led_tx
);

  // index 0 tx, 1 rx, 2 link down
  logic [2:0]           trig;
  logic [LED_WIDTH-1:0] stretch [3];
  logic [2:0]           led_q;

  assign trig = {!phy_up, rx_event, tx_event};

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      stretch[0] <= '0;
      stretch[1] <= '0;
      // link counts as down until phy_up has been stable
      stretch[2] <= '1;
      led_q      <= 3'b100;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (trig[i]) begin
          stretch[i] <= '1;
        end else if (stretch[i][LED_WIDTH-1]) begin
          stretch[i] <= stretch[i] - 1'b1;
        end
        led_q[i] <= stretch[i][LED_WIDTH-1];
      end
    end
  end

  assign led_tx = led_q[0];
  assign led_rx = led_q[1];
  assign led_up = !led_q[2];

endmodule

`default_nettype wire

/* hdl/eth_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_core_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int RESET_HOLD = 8,
  parameter int LED_WIDTH  = 24
) (
  input  logic               clk,
  input  logic               mac_resetRR,
  // host
  input  logic               reg_wr,
  input  logic               reg_rd,
  input  eth_pkg::reg_addr_t reg_addr,
  input  eth_pkg::reg_data_t reg_wdata,
  output eth_pkg::reg_data_t reg_rdata,
  output logic               reg_rvalid,
  // application transmit
  input  logic               tx_valid,
  input  logic               tx_end_of_frame,
  input  eth_pkg::word_t     tx_data,
  input  eth_pkg::ip_addr_t  tx_dest_ip,
  input  eth_pkg::udp_port_t tx_dest_port,
  output logic               tx_overflow,
  // application receive
  output logic               rx_valid,
  output logic               rx_end_of_frame,
  output eth_pkg::word_t     rx_data,
  output eth_pkg::ip_addr_t  rx_source_ip,
  output eth_pkg::udp_port_t rx_source_port,
  output logic               rx_bad_frame,
  // mac side
  output logic               mac_tx_valid,
  output logic               mac_tx_last,
  output eth_pkg::word_t     mac_tx_data,
  input  logic               mac_rx_valid,
  input  logic               mac_rx_last,
  input  eth_pkg::word_t     mac_rx_data,
  input  logic               mac_rx_bad,
  // status
  input  logic               phy_up,
  output logic               led_up,
  output logic               led_rx,
  output logic               led_tx
);
  import eth_pkg::*;

  logic      app_rst;
  logic      soft_reset_req;
  logic      soft_reset_ack;
  logic      accept;
  logic      pop;
  logic      empty;
  word_t     head_word;
  logic      head_eof;
  ip_addr_t  head_ip;
  udp_port_t head_port;

  eth_cfg_if cfg ();

  eth_regs u_regs (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .reg_wr         (reg_wr),
    .reg_rd         (reg_rd),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .reg_rdata      (reg_rdata),
    .reg_rvalid     (reg_rvalid),
    .cfg            (cfg.regs),
    .soft_reset_req (soft_reset_req),
    .soft_reset_ack (soft_reset_ack)
  );

  eth_soft_reset #(
    .RESET_HOLD (RESET_HOLD)
  ) u_soft_reset (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .soft_reset_req (soft_reset_req),
    .soft_reset_ack (soft_reset_ack),
    .app_rst        (app_rst)
  );

  eth_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .clk       (clk),
    .app_rst   (app_rst),
    .push      (accept),
    .word      (tx_data),
    .eof       (tx_end_of_frame),
    .dest_ip   (tx_dest_ip),
    .dest_port (tx_dest_port),
    .pop       (pop),
    .head_word (head_word),
    .head_eof  (head_eof),
    .head_ip   (head_ip),
    .head_port (head_port),
    .empty     (empty),
    .overflow  (tx_overflow)
  );

  eth_tx_framer u_tx_framer (
    .clk          (clk),
    .app_rst      (app_rst),
    .cfg          (cfg.tx),
    .tx_valid     (tx_valid),
    .accept       (accept),
    .head_word    (head_word),
    .head_eof     (head_eof),
    .head_ip      (head_ip),
    .head_port    (head_port),
    .empty        (empty),
    .pop          (pop),
    .mac_tx_valid (mac_tx_valid),
    .mac_tx_last  (mac_tx_last),
    .mac_tx_data  (mac_tx_data)
  );

  eth_rx_parser u_rx_parser (
    .clk             (clk),
    .app_rst         (app_rst),
    .cfg             (cfg.rx),
    .mac_rx_valid    (mac_rx_valid),
    .mac_rx_last     (mac_rx_last),
    .mac_rx_data     (mac_rx_data),
    .mac_rx_bad      (mac_rx_bad),
    .rx_valid        (rx_valid),
    .rx_end_of_frame (rx_end_of_frame),
    .rx_data         (rx_data),
    .rx_source_ip    (rx_source_ip),
    .rx_source_port  (rx_source_port),
    .rx_bad_frame    (rx_bad_frame)
  );

  eth_led_stretch #(
    .LED_WIDTH (LED_WIDTH)
  ) u_led_stretch (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .phy_up      (phy_up),
    .tx_event    (mac_tx_last),
    .rx_event    (cfg.rx_frame_good),
    .led_up      (led_up),
    .led_rx      (led_rx),
    .led_tx      (led_tx)
  );

endmodule

`default_nettype wire

/* tb/eth_core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_core_properties (
  input logic clk,
  input logic mac_resetRR,
  input logic tx_overflow,
  input logic rx_valid,
  input logic reg_rd,
  input logic reg_rvalid,
  input logic mac_tx_valid,
  input logic mac_tx_last
);

  // app spacing keeps the buffer from filling
  a_no_overflow: assert property (@(posedge clk) disable iff (mac_resetRR) !tx_overflow)
    else $error("tx_overflow asserted");

  a_rx_quiet_in_reset: assert property (@(posedge clk)
    mac_resetRR && $past(mac_resetRR) |-> !rx_valid)
    else $error("rx_valid high during reset");

  a_read_latency: assert property (@(posedge clk) disable iff (mac_resetRR)
    reg_rvalid == $past(reg_rd))
    else $error("reg_rvalid does not follow reg_rd by one cycle");

  a_last_with_valid: assert property (@(posedge clk) disable iff (mac_resetRR)
    mac_tx_last |-> mac_tx_valid)
    else $error("mac_tx_last without mac_tx_valid");

endmodule

bind eth_core_top eth_core_properties props (
  .clk          (clk),
  .mac_resetRR  (mac_resetRR),
  .tx_overflow  (tx_overflow),
  .rx_valid     (rx_valid),
  .reg_rd       (reg_rd),
  .reg_rvalid   (reg_rvalid),
  .mac_tx_valid (mac_tx_valid),
  .mac_tx_last  (mac_tx_last)
);

`default_nettype wire

/* tb/eth_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_core_tb;
  import eth_pkg::*;

  localparam int        LED_W      = 4;
  localparam int        HOLD       = 8;
  localparam int        NUM_FRAMES = 6;
  localparam ip_addr_t  LIP        = 32'h0a00_0005;
  localparam udp_port_t LPORT      = 16'h1234;
  // sender used for injected frames
  localparam ip_addr_t  SRC_IP     = 32'hc0a8_0107;
  localparam udp_port_t SRC_PORT   = 16'h4321;

  typedef struct packed {
    logic [7:0] len;
    logic [7:0] seed_off;
    ip_addr_t   dest_ip;
    udp_port_t  dest_port;
    logic       bad;
    logic       en;
    logic       deliver;
  } frame_t;

  logic clk;
  logic mac_resetRR;
  logic reg_wr;
  logic reg_rd;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic reg_rvalid;
  logic tx_valid;
  logic tx_end_of_frame;
  word_t tx_data;
  ip_addr_t tx_dest_ip;
  udp_port_t tx_dest_port;
  logic tx_overflow;
  logic rx_valid;
  logic rx_end_of_frame;
  word_t rx_data;
  ip_addr_t rx_source_ip;
  udp_port_t rx_source_port;
  logic rx_bad_frame;
  logic mac_tx_valid;
  logic mac_tx_last;
  word_t mac_tx_data;
  logic mac_rx_valid;
  logic mac_rx_last;
  word_t mac_rx_data;
  logic mac_rx_bad;
  logic phy_up;
  logic led_up;
  logic led_rx;
  logic led_tx;

  frame_t frames [NUM_FRAMES];
  word_t  frame_q[$];
  int     cyc;
  int     limit;
  count_t tx_exp;
  count_t good_exp;
  count_t bad_exp;

  eth_core_top #(
    .FIFO_DEPTH (16),
    .RESET_HOLD (HOLD),
    .LED_WIDTH  (LED_W)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc > limit) begin
      $display("timeout: run went past %0d cycles", limit);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (exp !== got) begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t got);
    if (exp !== got) begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t got);
    if (exp !== got) begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_port(input string name, input udp_port_t exp, input udp_port_t got);
    if (exp !== got) begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (exp !== got) begin
      $display("ERR %0t %s: expected %b, got %b", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(posedge clk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    #1;
    reg_rd = 1'b0;
    @(negedge clk);
    check_bit("reg_rvalid", 1'b1, reg_rvalid);
    data = reg_rdata;
  endtask

  task automatic check_counters();
    reg_data_t d;
    reg_read(REG_TX_FRAMES, d);
    check_reg("REG_TX_FRAMES", {16'h0, tx_exp}, d);
    reg_read(REG_RX_GOOD, d);
    check_reg("REG_RX_GOOD", {16'h0, good_exp}, d);
    reg_read(REG_RX_BAD, d);
    check_reg("REG_RX_BAD", {16'h0, bad_exp}, d);
  endtask

  // header words then payload from the seeded generator
  task automatic build_frame(input frame_t f, input ip_addr_t src_ip, input udp_port_t src_port);
    integer seed;
    seed = 32'h0be2_c7ec + f.seed_off;
    frame_q = {};
    frame_q.push_back({f.dest_ip, src_ip});
    frame_q.push_back({f.dest_port, src_port, 32'h0});
    for (int k = 0; k < f.len; k++) begin
      frame_q.push_back({32'($random(seed)), 32'($random(seed))});
    end
  endtask

  task automatic send_app(input frame_t f);
    for (int k = 0; k < f.len; k++) begin
      @(posedge clk);
      #1;
      tx_valid        = 1'b1;
      tx_data         = frame_q[k + 2];
      tx_end_of_frame = (k == f.len - 1);
      tx_dest_ip      = f.dest_ip;
      tx_dest_port    = f.dest_port;
    end
    @(posedge clk);
    #1;
    tx_valid        = 1'b0;
    tx_end_of_frame = 1'b0;
  endtask

  // frame must leave on consecutive cycles once started
  task automatic capture_tx();
    int got;
    got = 0;
    while (got < frame_q.size()) begin
      @(negedge clk);
      check_bit("tx_overflow", 1'b0, tx_overflow);
      if (got > 0 || mac_tx_valid) begin
        check_bit("mac_tx_valid", 1'b1, mac_tx_valid);
        check_word("mac_tx_data", frame_q[got], mac_tx_data);
        check_bit("mac_tx_last", got == frame_q.size() - 1, mac_tx_last);
        got++;
      end
    end
  endtask

  task automatic replay_rx(input frame_t f, input ip_addr_t src_ip, input udp_port_t src_port);
    int  n;
    logic exp_v;
    n = frame_q.size();
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      #1;
      mac_rx_valid = (i < n);
      mac_rx_last  = (i == n - 1);
      mac_rx_bad   = f.bad && (i == n - 1);
      mac_rx_data  = (i < n) ? frame_q[i] : '0;
      @(negedge clk);
      exp_v = f.deliver && (i >= 3);
      check_bit("rx_valid", exp_v, rx_valid);
      if (exp_v) begin
        check_word("rx_data", frame_q[i - 1], rx_data);
        check_bit("rx_end_of_frame", i == n, rx_end_of_frame);
        check_bit("rx_bad_frame", f.bad && (i == n), rx_bad_frame);
        check_ip("rx_source_ip", src_ip, rx_source_ip);
        check_port("rx_source_port", src_port, rx_source_port);
      end
    end
  endtask

  task automatic apply_entry(input frame_t f);
    logic inject;
    inject = !f.en || f.bad || f.dest_ip != LIP || f.dest_port != LPORT;
    if (!f.en) begin
      reg_write(REG_CTRL, 32'h0);
    end
    if (inject) begin
      build_frame(f, SRC_IP, SRC_PORT);
      replay_rx(f, SRC_IP, SRC_PORT);
    end else begin
      build_frame(f, LIP, LPORT);
      fork
        send_app(f);
        capture_tx();
      join
      tx_exp++;
      replay_rx(f, LIP, LPORT);
    end
    if (f.deliver && f.bad) begin
      bad_exp++;
    end else if (f.deliver) begin
      good_exp++;
    end
    if (!f.en) begin
      reg_write(REG_CTRL, 32'h1);
    end
    check_counters();
  endtask

  initial begin
    reg_data_t d;
    int        t0;
    int        k;
    mac_resetRR = 1'b1;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    tx_valid = 1'b0;
    tx_end_of_frame = 1'b0;
    tx_data = '0;
    tx_dest_ip = '0;
    tx_dest_port = '0;
    mac_rx_valid = 1'b0;
    mac_rx_last = 1'b0;
    mac_rx_data = '0;
    mac_rx_bad = 1'b0;
    phy_up = 1'b1;
    cyc = 0;
    tx_exp = '0;
    good_exp = '0;
    bad_exp = '0;

    // len, seed offset, dest ip, dest port, bad, enable, delivered
    frames[0] = '{8'd4, 8'd0, LIP, LPORT, 1'b0, 1'b1, 1'b1};
    frames[1] = '{8'd1, 8'd1, LIP, LPORT, 1'b0, 1'b1, 1'b1};
    frames[2] = '{8'd3, 8'd2, 32'h0a00_0099, LPORT, 1'b0, 1'b1, 1'b0};
    frames[3] = '{8'd2, 8'd3, LIP, 16'h5555, 1'b0, 1'b1, 1'b0};
    frames[4] = '{8'd2, 8'd4, LIP, LPORT, 1'b1, 1'b1, 1'b1};
    frames[5] = '{8'd3, 8'd5, LIP, LPORT, 1'b0, 1'b0, 1'b0};
    limit = 0;
    for (int i = 0; i < NUM_FRAMES; i++) begin
      limit += frames[i].len + 40;
    end
    // register, soft reset and led phases
    limit += 4 * 40;

    repeat (5) @(posedge clk);
    #1;
    mac_resetRR = 1'b0;

    check_counters();
    reg_write(REG_LOCAL_IP, LIP);
    reg_write(REG_LOCAL_PORT, {16'h0, LPORT});
    reg_write(REG_CTRL, 32'h1);
    reg_read(REG_LOCAL_IP, d);
    check_reg("REG_LOCAL_IP", LIP, d);
    reg_read(REG_LOCAL_PORT, d);
    check_reg("REG_LOCAL_PORT", {16'h0, LPORT}, d);
    reg_read(REG_CTRL, d);
    check_reg("REG_CTRL", 32'h1, d);

    for (int i = 0; i < NUM_FRAMES; i++) begin
      apply_entry(frames[i]);
    end

    // soft reset keeps registers and counters
    reg_write(REG_CTRL, 32'h3);
    t0 = cyc;
    reg_read(REG_CTRL, d);
    check_bit("REG_CTRL busy", 1'b1, d[1]);
    while (d[1]) begin
      reg_read(REG_CTRL, d);
      if (cyc - t0 > HOLD + 4) begin
        $display("soft reset busy bit did not clear within %0d cycles", HOLD + 4);
        stop_run();
      end
    end
    check_reg("REG_CTRL", 32'h1, d);
    reg_read(REG_LOCAL_IP, d);
    check_reg("REG_LOCAL_IP", LIP, d);
    check_counters();
    apply_entry(frames[0]);

    // tx indicator stretch
    build_frame(frames[1], LIP, LPORT);
    fork
      send_app(frames[1]);
      capture_tx();
    join
    tx_exp++;
    k = 0;
    while (k < 4 && !led_tx) begin
      @(negedge clk);
      k++;
    end
    check_bit("led_tx", 1'b1, led_tx);
    k = 0;
    while (k <= (2 ** LED_W) + 4 && led_tx) begin
      @(negedge clk);
      k++;
    end
    check_bit("led_tx", 1'b0, led_tx);

    // rx indicator follows a good frame
    check_bit("led_rx", 1'b0, led_rx);
    replay_rx(frames[1], LIP, LPORT);
    good_exp++;
    k = 0;
    while (k < 4 && !led_rx) begin
      @(negedge clk);
      k++;
    end
    check_bit("led_rx", 1'b1, led_rx);

    check_bit("led_up", 1'b1, led_up);
    @(posedge clk);
    #1;
    phy_up = 1'b0;
    // counter reloads on the next edge, indicator one edge later
    repeat (3) @(negedge clk);
    check_bit("led_up", 1'b0, led_up);
    phy_up = 1'b1;
    check_counters();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* eth_core.f */
hdl/eth_pkg.sv
hdl/eth_cfg_if.sv
hdl/eth_regs.sv
hdl/eth_tx_fifo.sv
hdl/eth_tx_framer.sv
hdl/eth_rx_parser.sv
hdl/eth_soft_reset.sv
hdl/eth_led_stretch.sv
hdl/eth_core_top.sv
tb/eth_core_properties.sv
tb/eth_core_tb.sv

/* Makefile */
SIM := obj_dir/Veth_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -j 0 --top-module eth_core_tb -f eth_core.f
	$(SIM) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
